//--- common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// width of a data word, which is also the width of a memory word and an address.
`define CPU_WORD_W 32

`define CPU_NUM_REGS 16

// first instruction fetch address after reset.
`define CPU_RESET_PC 32'h0000_0000

`endif

//--- common/cpuIsa_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpuIsa_pkg;

        typedef logic [`CPU_WORD_W-1:0] word_t;
        typedef logic [3:0] regIdx_t;
        typedef logic [18:0] imm_t;

        // load, store and ALU codes are dense, and halt has a code of its own far above them.
        typedef enum logic [4:0] {
                OpLd   = 5'b00000,
                OpLdi  = 5'b00001,
                OpSt   = 5'b00010,
                OpAdd  = 5'b00011,
                OpSub  = 5'b00100,
                OpAnd  = 5'b00101,
                OpOr   = 5'b00110,
                OpHalt = 5'b11011
        } opcode_t;

        // instruction field positions; the constant overlaps the Rc field.
        localparam int OpcodeHi = 31;
        localparam int OpcodeLo = 27;
        localparam int RaHi = 26;
        localparam int RaLo = 23;
        localparam int RbHi = 22;
        localparam int RbLo = 19;
        localparam int RcHi = 18;
        localparam int RcLo = 15;
        localparam int ImmHi = 18;
        localparam int ImmLo = 0;

endpackage

`default_nettype wire

//--- common/cpuCtl_pkg.sv
`default_nettype none

package cpuCtl_pkg;

        // one state per T phase of the instruction, plus a parking state.
        typedef enum logic [3:0] {
                StFetch0,
                StFetch1,
                StFetch2,
                StExec3,
                StExec4,
                StExec5,
                StExec6,
                StExec7,
                StHalt
        } ctlState_t;

        typedef enum logic [2:0] {
                SrcNone,
                SrcPc,
                SrcMdr,
                SrcZ,
                SrcReg,
                SrcConst
        } busSrc_t;

        typedef enum logic [2:0] {
                AluAdd,
                AluSub,
                AluAnd,
                AluOr,
                AluInc
        } aluOp_t;

        // which IR field addresses the register file.
        typedef enum logic [1:0] {
                SelRa,
                SelRb,
                SelRc
        } regSel_t;

endpackage

`default_nettype wire

//--- common/ctlBus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctlBus_if;
        import cpuIsa_pkg::*;
        import cpuCtl_pkg::*;

        busSrc_t busSrc;
        regSel_t regSel;
        logic regWrite;
        logic baOut;
        logic marIn;
        logic mdrIn;
        logic yIn;
        logic zIn;
        logic pcIn;
        logic irIn;
        aluOp_t aluOp;
        logic memRead;
        logic memWrite;

        // status returned by the datapath.
        opcode_t opcode;
        logic memDone;

        modport ctl (
                output busSrc,
                output regSel,
                output regWrite,
                output baOut,
                output marIn,
                output mdrIn,
                output yIn,
                output zIn,
                output pcIn,
                output irIn,
                output aluOp,
                output memRead,
                output memWrite,
                input opcode,
                input memDone
        );

        modport dp (
                input busSrc,
                input regSel,
                input regWrite,
                input baOut,
                input marIn,
                input mdrIn,
                input yIn,
                input zIn,
                input pcIn,
                input irIn,
                input aluOp,
                input memRead,
                input memWrite,
                output opcode,
                output memDone
        );

endinterface

`default_nettype wire

//--- hw/datapath/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module registerFile (
        input logic Clock,
        input logic rst,
        input cpuIsa_pkg::word_t ir,
        input cpuCtl_pkg::regSel_t regSel,
        input logic regWrite,
        input logic baOut,
        input cpuIsa_pkg::word_t busIn,
        output cpuIsa_pkg::word_t regOut
);
        import cpuIsa_pkg::*;
        import cpuCtl_pkg::*;

        word_t regs [`CPU_NUM_REGS];
        regIdx_t regNum;

        always_comb begin
                case (regSel)
                SelRa: regNum = ir[RaHi:RaLo];
                SelRb: regNum = ir[RbHi:RbLo];
                SelRc: regNum = ir[RcHi:RcLo];
                default: regNum = ir[RaHi:RaLo];
                endcase
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (regWrite) begin
                        regs[regNum] <= busIn;
                end
        end

        // R0 reads as zero only when it serves as a base address.
        assign regOut = (baOut && regNum == '0) ? '0 : regs[regNum];

endmodule

`default_nettype wire

//--- hw/datapath/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
        input cpuCtl_pkg::aluOp_t aluOp,
        input cpuIsa_pkg::word_t a,
        input cpuIsa_pkg::word_t b,
        output cpuIsa_pkg::word_t result
);
        import cpuCtl_pkg::*;

        // sums wrap at the word width.
        always_comb begin
                case (aluOp)
                AluAdd: result = a + b;
                AluSub: result = a - b;
                AluAnd: result = a & b;
                AluOr: result = a | b;
                AluInc: result = a + 1'b1;
                default: result = a + b;
                endcase
        end

endmodule

`default_nettype wire

//--- hw/datapath/memInterface.sv
`timescale 1ns/1ps
`default_nettype none

module memInterface (
        input logic Clock,
        input logic rst,
        input cpuIsa_pkg::word_t busIn,
        input logic marIn,
        input logic mdrIn,
        input logic memRead,
        input logic memWrite,
        output cpuIsa_pkg::word_t mdrOut,
        output logic memDone,
        output cpuIsa_pkg::word_t wbAdr,
        output cpuIsa_pkg::word_t wbDatOut,
        input cpuIsa_pkg::word_t wbDatIn,
        output logic wbCyc,
        output logic wbStb,
        output logic wbWe,
        input logic wbAck
);
        import cpuIsa_pkg::*;

        typedef enum logic {
                MemIdle,
                MemBusy
        } memState_t;

        memState_t memState;
        word_t marQ;
        word_t mdrQ;
        logic memStart;

        // the request is still up in the done cycle, so it must not start a second access.
        assign memStart = (memRead || memWrite) && !memDone;

        always_ff @(posedge Clock) begin
                if (rst) begin
                        memState <= MemIdle;
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        wbWe <= 1'b0;
                        memDone <= 1'b0;
                end else begin
                        memDone <= 1'b0;
                        case (memState)
                        MemIdle: begin
                                if (memStart) begin
                                        memState <= MemBusy;
                                        wbCyc <= 1'b1;
                                        wbStb <= 1'b1;
                                        wbWe <= memWrite;
                                end
                        end
                        MemBusy: begin
                                if (wbAck) begin
                                        memState <= MemIdle;
                                        wbCyc <= 1'b0;
                                        wbStb <= 1'b0;
                                        wbWe <= 1'b0;
                                        memDone <= 1'b1;
                                end
                        end
                        default: memState <= MemIdle;
                        endcase
                end
        end

        always_ff @(posedge Clock) begin
                if (marIn) marQ <= busIn;
                if (mdrIn) begin
                        mdrQ <= busIn;
                end else if (memState == MemBusy && wbAck && !wbWe) begin
                        mdrQ <= wbDatIn;
                end
        end

        assign wbAdr = marQ;
        assign wbDatOut = mdrQ;
        assign mdrOut = mdrQ;

endmodule

`default_nettype wire

//--- hw/datapath/busDatapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module busDatapath (
        input logic Clock,
        input logic rst,
        ctlBus_if.dp dp,
        output cpuIsa_pkg::word_t wbAdr,
        output cpuIsa_pkg::word_t wbDatOut,
        input cpuIsa_pkg::word_t wbDatIn,
        output logic wbCyc,
        output logic wbStb,
        output logic wbWe,
        input logic wbAck
);
        import cpuIsa_pkg::*;
        import cpuCtl_pkg::*;

        word_t pcQ;
        word_t irQ;
        word_t yQ;
        word_t zQ;
        word_t busWord;
        word_t regOut;
        word_t mdrOut;
        word_t aluA;
        word_t aluResult;
        word_t constExt;
        imm_t immField;

        assign immField = irQ[ImmHi:ImmLo];
        assign constExt = {{(`CPU_WORD_W - $bits(imm_t)){immField[$bits(imm_t)-1]}}, immField};
        assign dp.opcode = opcode_t'(irQ[OpcodeHi:OpcodeLo]);

        // the incrementer works on the PC, every other operation on Y.
        assign aluA = (dp.aluOp == AluInc) ? pcQ : yQ;

        always_comb begin
                case (dp.busSrc)
                SrcPc: busWord = pcQ;
                SrcMdr: busWord = mdrOut;
                SrcZ: busWord = zQ;
                SrcReg: busWord = regOut;
                SrcConst: busWord = constExt;
                default: busWord = '0;
                endcase
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        pcQ <= `CPU_RESET_PC;
                        irQ <= '0;
                end else begin
                        if (dp.pcIn) pcQ <= aluResult;
                        if (dp.irIn) irQ <= busWord;
                end
        end

        always_ff @(posedge Clock) begin
                if (dp.yIn) yQ <= busWord;
                if (dp.zIn) zQ <= aluResult;
        end

        registerFile i_registerFile (
                .Clock(Clock),
                .rst(rst),
                .ir(irQ),
                .regSel(dp.regSel),
                .regWrite(dp.regWrite),
                .baOut(dp.baOut),
                .busIn(busWord),
                .regOut(regOut)
        );

        aluUnit i_aluUnit (
                .aluOp(dp.aluOp),
                .a(aluA),
                .b(busWord),
                .result(aluResult)
        );

        memInterface i_memInterface (
                .Clock(Clock),
                .rst(rst),
                .busIn(busWord),
                .marIn(dp.marIn),
                .mdrIn(dp.mdrIn),
                .memRead(dp.memRead),
                .memWrite(dp.memWrite),
                .mdrOut(mdrOut),
                .memDone(dp.memDone),
                .wbAdr(wbAdr),
                .wbDatOut(wbDatOut),
                .wbDatIn(wbDatIn),
                .wbCyc(wbCyc),
                .wbStb(wbStb),
                .wbWe(wbWe),
                .wbAck(wbAck)
        );

endmodule

`default_nettype wire

//--- hw/control/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
        input logic Clock,
        input logic rst,
        ctlBus_if.ctl ctl,
        output logic halted
);
        import cpuIsa_pkg::*;
        import cpuCtl_pkg::*;

        ctlState_t state;
        ctlState_t stateNext;
        logic isAluOp;
        logic isMemOp;

        function automatic aluOp_t aluOpFor(opcode_t op);
                case (op)
                OpSub: return AluSub;
                OpAnd: return AluAnd;
                OpOr: return AluOr;
                default: return AluAdd;
                endcase
        endfunction

        assign isAluOp = ctl.opcode inside {OpAdd, OpSub, OpAnd, OpOr};
        assign isMemOp = ctl.opcode inside {OpLd, OpSt};
        assign halted = (state == StHalt);

        always_ff @(posedge Clock) begin
                if (rst) begin
                        state <= StFetch0;
                end else begin
                        state <= stateNext;
                end
        end

        // memory phases hold until the interface reports the ack.
        always_comb begin
                stateNext = state;
                case (state)
                StFetch0: stateNext = StFetch1;
                StFetch1: if (ctl.memDone) stateNext = StFetch2;
                StFetch2: stateNext = StExec3;
                StExec3: begin
                        if (ctl.opcode == OpHalt) begin
                                stateNext = StHalt;
                        end else if (isAluOp || isMemOp || ctl.opcode == OpLdi) begin
                                stateNext = StExec4;
                        end else begin
                                stateNext = StFetch0;
                        end
                end
                StExec4: stateNext = StExec5;
                StExec5: stateNext = isMemOp ? StExec6 : StFetch0;
                StExec6: begin
                        if (ctl.memDone) begin
                                stateNext = (ctl.opcode == OpLd) ? StExec7 : StFetch0;
                        end
                end
                StExec7: stateNext = StFetch0;
                StHalt: stateNext = StHalt;
                default: stateNext = StFetch0;
                endcase
        end

        always_comb begin
                ctl.busSrc = SrcNone;
                ctl.regSel = SelRa;
                ctl.regWrite = 1'b0;
                ctl.baOut = 1'b0;
                ctl.marIn = 1'b0;
                ctl.mdrIn = 1'b0;
                ctl.yIn = 1'b0;
                ctl.zIn = 1'b0;
                ctl.pcIn = 1'b0;
                ctl.irIn = 1'b0;
                ctl.aluOp = AluAdd;
                ctl.memRead = 1'b0;
                ctl.memWrite = 1'b0;
                case (state)
                StFetch0: begin
                        ctl.busSrc = SrcPc;
                        ctl.marIn = 1'b1;
                        ctl.aluOp = AluInc;
                        ctl.pcIn = 1'b1;
                end
                StFetch1: ctl.memRead = 1'b1;
                StFetch2: begin
                        ctl.busSrc = SrcMdr;
                        ctl.irIn = 1'b1;
                end
                StExec3: begin
                        // address forming ops see zero when the base is R0.
                        ctl.busSrc = SrcReg;
                        ctl.regSel = SelRb;
                        ctl.baOut = !isAluOp;
                        ctl.yIn = 1'b1;
                end
                StExec4: begin
                        ctl.zIn = 1'b1;
                        if (isAluOp) begin
                                ctl.busSrc = SrcReg;
                                ctl.regSel = SelRc;
                                ctl.aluOp = aluOpFor(ctl.opcode);
                        end else begin
                                ctl.busSrc = SrcConst;
                        end
                end
                StExec5: begin
                        ctl.busSrc = SrcZ;
                        if (isMemOp) begin
                                ctl.marIn = 1'b1;
                        end else begin
                                ctl.regWrite = 1'b1;
                        end
                end
                StExec6: begin
                        if (ctl.opcode == OpLd) begin
                                ctl.memRead = 1'b1;
                        end else begin
                                // MDR picks up Ra on the same edge that launches the write.
                                ctl.busSrc = SrcReg;
                                ctl.mdrIn = 1'b1;
                                ctl.memWrite = 1'b1;
                        end
                end
                StExec7: begin
                        ctl.busSrc = SrcMdr;
                        ctl.regWrite = 1'b1;
                end
                default: ;
                endcase
        end

endmodule

`default_nettype wire

//--- hw/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
        input logic Clock,
        input logic rst,
        output cpuIsa_pkg::word_t wbAdr,
        output cpuIsa_pkg::word_t wbDatOut,
        input cpuIsa_pkg::word_t wbDatIn,
        output logic wbCyc,
        output logic wbStb,
        output logic wbWe,
        input logic wbAck,
        output logic halted
);
        ctlBus_if ctlBus ();

        controlUnit i_controlUnit (
                .Clock(Clock),
                .rst(rst),
                .ctl(ctlBus.ctl),
                .halted(halted)
        );

        busDatapath i_busDatapath (
                .Clock(Clock),
                .rst(rst),
                .dp(ctlBus.dp),
                .wbAdr(wbAdr),
                .wbDatOut(wbDatOut),
                .wbDatIn(wbDatIn),
                .wbCyc(wbCyc),
                .wbStb(wbStb),
                .wbWe(wbWe),
                .wbAck(wbAck)
        );

endmodule

`default_nettype wire

//--- sim/cpuCore_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore_assert (
        input logic Clock,
        input logic rst,
        input cpuIsa_pkg::word_t wbAdr,
        input cpuIsa_pkg::word_t wbDatOut,
        input logic wbCyc,
        input logic wbStb,
        input logic wbWe,
        input logic wbAck,
        input logic halted
);

        stbInCycle: assert property (@(posedge Clock) disable iff (rst) wbStb |-> wbCyc)
                else $error("wbStb is high outside a Wishbone cycle");

        // the master holds its request until the slave acks.
        requestStable: assert property (@(posedge Clock) disable iff (rst)
                wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbWe) && $stable(wbDatOut))
                else $error("Wishbone request changed before the ack");

        haltSticky: assert property (@(posedge Clock) disable iff (rst) !$fell(halted))
                else $error("halted fell without a reset");

endmodule

bind cpuCore cpuCore_assert i_cpuCoreAssert (
        .Clock(Clock),
        .rst(rst),
        .wbAdr(wbAdr),
        .wbDatOut(wbDatOut),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAck(wbAck),
        .halted(halted)
);

`default_nettype wire

//--- sim/cpuCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpuCore_tb;
        import cpuIsa_pkg::*;

        localparam int MemWords = 256;
        localparam int DataBase = 128;

        logic Clock;
        logic rst;
        word_t wbAdr;
        word_t wbDatOut;
        word_t wbDatIn;
        logic wbCyc;
        logic wbStb;
        logic wbWe;
        logic wbAck;
        logic halted;

        word_t mem [MemWords];
        word_t image [MemWords];
        word_t expAdr [$];
        word_t expDat [$];
        opcode_t aluOps [4] = '{OpAdd, OpSub, OpAnd, OpOr};
        logic [31:0] lcgState;
        logic inCycle;
        int waitLeft;
        int pcFill;
        int errors = 0;
        int tests = 0;
        int obsStores = 0;
        int expStores = 0;
        int cycleCount = 0;
        int testStartCycle = 0;
        int cycleLimit = 1000;
        string testName = "none";

        cpuCore i_cpuCore (
                .Clock(Clock),
                .rst(rst),
                .wbAdr(wbAdr),
                .wbDatOut(wbDatOut),
                .wbDatIn(wbDatIn),
                .wbCyc(wbCyc),
                .wbStb(wbStb),
                .wbWe(wbWe),
                .wbAck(wbAck),
                .halted(halted)
        );

        initial begin
                Clock = 1'b0;
                forever #5 Clock = ~Clock;
        end

        function automatic word_t nextRand();
                lcgState = lcgState * 32'd1664525 + 32'd1013904223;
                return lcgState;
        endfunction

        function automatic word_t encodeReg(opcode_t op, int ra, int rb, int rc);
                return {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
        endfunction

        function automatic word_t encodeImm(opcode_t op, int ra, int rb, int c);
                return {op, ra[3:0], rb[3:0], c[18:0]};
        endfunction

        task automatic check(input string what, input word_t expected, input word_t actual);
                if (expected !== actual) begin
                        $display("[FAIL] %s %s: expected %h, got %h", testName, what,
                                 expected, actual);
                        errors++;
                end
        endtask

        // ISA model of the program in image; fills the expected store queues.
        function automatic int referenceRun();
                word_t m [MemWords];
                word_t r [16];
                word_t ir;
                word_t imm;
                word_t base;
                word_t addr;
                word_t pc;
                opcode_t op;
                int count;
                logic done;
                m = image;
                pc = `CPU_RESET_PC;
                count = 0;
                done = 1'b0;
                expAdr.delete();
                expDat.delete();
                for (int i = 0; i < 16; i++) begin
                        r[i] = '0;
                end
                while (!done && count < MemWords) begin
                        ir = m[pc[7:0]];
                        pc = pc + 1;
                        count++;
                        op = opcode_t'(ir[31:27]);
                        imm = {{13{ir[18]}}, ir[18:0]};
                        base = (ir[22:19] == 4'd0) ? '0 : r[ir[22:19]];
                        addr = base + imm;
                        case (op)
                        OpLd: r[ir[26:23]] = m[addr[7:0]];
                        OpLdi: r[ir[26:23]] = addr;
                        OpSt: begin
                                m[addr[7:0]] = r[ir[26:23]];
                                expAdr.push_back(addr);
                                expDat.push_back(r[ir[26:23]]);
                        end
                        OpAdd: r[ir[26:23]] = r[ir[22:19]] + r[ir[18:15]];
                        OpSub: r[ir[26:23]] = r[ir[22:19]] - r[ir[18:15]];
                        OpAnd: r[ir[26:23]] = r[ir[22:19]] & r[ir[18:15]];
                        OpOr: r[ir[26:23]] = r[ir[22:19]] | r[ir[18:15]];
                        default: done = 1'b1;
                        endcase
                end
                return count;
        endfunction

        task automatic clearImage();
                for (int i = 0; i < MemWords; i++) begin
                        image[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0]};
                end
                pcFill = 0;
        endtask

        task automatic emit(input word_t instr);
                image[pcFill] = instr;
                pcFill++;
        endtask

        task automatic buildCopyTest();
                clearImage();
                for (int k = 0; k < 6; k++) begin
                        image[DataBase + k] = nextRand();
                end
                for (int k = 0; k < 4; k++) begin
                        emit(encodeImm(OpLd, 1 + k, 0, DataBase + k));
                        emit(encodeImm(OpSt, 1 + k, 0, DataBase + 32 + k));
                end
                emit(encodeImm(OpLdi, 6, 0, DataBase + 4));
                emit(encodeImm(OpLd, 7, 6, 1));
                emit(encodeImm(OpSt, 7, 6, 40));
                emit(encodeImm(OpSt, 7, 6, -3));
                emit(encodeReg(OpHalt, 0, 0, 0));
        endtask

        task automatic buildLdiTest();
                word_t rnd;
                clearImage();
                // R0 holds a nonzero value, so every zero base below has to come from the gating.
                emit(encodeImm(OpLdi, 0, 0, -99));
                emit(encodeImm(OpLdi, 1, 0, 1234));
                emit(encodeImm(OpLdi, 2, 0, -5));
                emit(encodeImm(OpLdi, 3, 0, 262143));
                emit(encodeImm(OpLdi, 4, 0, -262144));
                emit(encodeImm(OpLdi, 5, 0, 150));
                emit(encodeImm(OpLdi, 6, 5, -7));
                emit(encodeImm(OpLdi, 7, 5, 33));
                emit(encodeImm(OpSt, 0, 0, 200));
                for (int k = 1; k < 8; k++) begin
                        emit(encodeImm(OpSt, k, 0, 200 + k));
                end
                // a negative offset from a nonzero base.
                emit(encodeImm(OpSt, 2, 5, -20));
                for (int k = 0; k < 3; k++) begin
                        rnd = nextRand();
                        emit(encodeImm(OpLdi, 8 + k, 0, rnd));
                        emit(encodeImm(OpSt, 8 + k, 0, 220 + k));
                end
                emit(encodeReg(OpHalt, 0, 0, 0));
        endtask

        task automatic buildAluTest();
                clearImage();
                image[DataBase] = nextRand();
                image[DataBase + 1] = nextRand();
                image[DataBase + 2] = 32'hffff_fffe;
                for (int k = 0; k < 3; k++) begin
                        emit(encodeImm(OpLd, 1 + k, 0, DataBase + k));
                end
                for (int k = 0; k < 4; k++) begin
                        emit(encodeReg(aluOps[k], 4, 1, 2));
                        emit(encodeImm(OpSt, 4, 0, 160 + k));
                end
                // sums and differences that wrap past the word width.
                emit(encodeReg(OpAdd, 5, 3, 3));
                emit(encodeReg(OpSub, 6, 0, 1));
                emit(encodeReg(OpSub, 7, 2, 3));
                emit(encodeImm(OpSt, 5, 0, 170));
                emit(encodeImm(OpSt, 6, 0, 171));
                emit(encodeImm(OpSt, 7, 0, 172));
                emit(encodeReg(OpHalt, 0, 0, 0));
        endtask

        task automatic buildMixedTest();
                word_t rnd;
                int ra;
                clearImage();
                for (int k = 1; k < 8; k++) begin
                        image[DataBase + k] = nextRand();
                        emit(encodeImm(OpLd, k, 0, DataBase + k));
                end
                for (int n = 0; n < 12; n++) begin
                        rnd = nextRand();
                        ra = 1 + rnd[7:4] % 7;
                        emit(encodeReg(aluOps[rnd[1:0]], ra, 1 + rnd[11:8] % 7, rnd[15:12] % 8));
                        emit(encodeImm(OpSt, ra, 0, 176 + n));
                end
                emit(encodeReg(OpHalt, 0, 0, 0));
        endtask

        task automatic ackAccess();
                wbAck <= 1'b1;
                if (wbWe) begin
                        mem[wbAdr[7:0]] <= wbDatOut;
                end else begin
                        wbDatIn <= mem[wbAdr[7:0]];
                end
        endtask

        // Wishbone slave that inserts 0 to 3 wait cycles per access.
        always @(posedge Clock) begin
                int draw;
                draw = 0;
                if (rst) begin
                        wbAck <= 1'b0;
                        inCycle <= 1'b0;
                        waitLeft <= 0;
                end else if (wbAck) begin
                        wbAck <= 1'b0;
                        inCycle <= 1'b0;
                end else if (wbCyc && wbStb) begin
                        if (inCycle && waitLeft == 0) begin
                                ackAccess();
                        end else if (inCycle) begin
                                waitLeft <= waitLeft - 1;
                        end else begin
                                draw = nextRand() >> 30;
                                inCycle <= 1'b1;
                                if (draw == 0) begin
                                        ackAccess();
                                end else begin
                                        waitLeft <= draw - 1;
                                end
                        end
                end
        end

        always @(negedge Clock) begin
                word_t adr;
                word_t dat;
                if (!rst && wbCyc && wbStb && wbWe && wbAck) begin
                        obsStores++;
                        if (expAdr.size() == 0) begin
                                $display("test %s wrote %h to %h, a store the model never makes",
                                         testName, wbDatOut, wbAdr);
                                errors++;
                        end else begin
                                adr = expAdr.pop_front();
                                dat = expDat.pop_front();
                                check("store address", adr, wbAdr);
                                check("store data", dat, wbDatOut);
                        end
                end
        end

        always @(posedge Clock) begin
                if (cycleCount - testStartCycle > cycleLimit) begin
                        $display("timeout: test %s did not finish within %0d cycles",
                                 testName, cycleLimit);
                        $display("ERRORS FOUND");
                        $finish;
                end else begin
                        cycleCount <= cycleCount + 1;
                end
        end

        task automatic runTest(input string name);
                int instrCount;
                int errBefore;
                logic busAfterHalt;
                instrCount = referenceRun();
                expStores = expAdr.size();
                errBefore = errors;
                testName = name;
                mem = image;
                obsStores = 0;
                busAfterHalt = 1'b0;
                testStartCycle = cycleCount;
                cycleLimit = instrCount * 8 * 4 + 100;
                @(posedge Clock);
                rst <= 1'b1;
                repeat (4) @(posedge Clock);
                @(negedge Clock);
                check("wbCyc in reset", 0, wbCyc);
                check("wbStb in reset", 0, wbStb);
                check("wbWe in reset", 0, wbWe);
                check("halted in reset", 0, halted);
                @(posedge Clock);
                rst <= 1'b0;
                while (!wbCyc) @(negedge Clock);
                check("first access wbWe", 0, wbWe);
                check("first access address", `CPU_RESET_PC, wbAdr);
                while (!halted) @(negedge Clock);
                repeat (50) begin
                        @(negedge Clock);
                        busAfterHalt = busAfterHalt | wbCyc;
                end
                check("bus cycle after halt", 0, busAfterHalt);
                check("store count", expStores, obsStores);
                tests++;
                $display("test %s: %0d instructions, %0d stores, %s", name, instrCount,
                         obsStores, (errors == errBefore) ? "passed" : "failed");
        endtask

        initial begin
                rst = 1'b1;
                wbAck = 1'b0;
                wbDatIn = '0;
                lcgState = 32'ha93e2650;
                buildCopyTest();
                runTest("copy");
                buildLdiTest();
                runTest("ldi");
                buildAluTest();
                runTest("alu");
                buildMixedTest();
                runTest("mixed");
                $display("%0d tests run, %0d errors", tests, errors);
                if (errors == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/cpuIsa_pkg.sv
common/cpuCtl_pkg.sv
common/ctlBus_if.sv
hw/datapath/registerFile.sv
hw/datapath/aluUnit.sv
hw/datapath/memInterface.sv
hw/datapath/busDatapath.sv
hw/control/controlUnit.sv
hw/cpuCore.sv
sim/cpuCore_assert.sv
sim/cpuCore_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - common
    files:
      - common/cpuIsa_pkg.sv
      - common/cpuCtl_pkg.sv
      - common/ctlBus_if.sv
      - hw/datapath/registerFile.sv
      - hw/datapath/aluUnit.sv
      - hw/datapath/memInterface.sv
      - hw/datapath/busDatapath.sv
      - hw/control/controlUnit.sv
      - hw/cpuCore.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/cpuCore_assert.sv
      - sim/cpuCore_tb.sv
